/* all.f */
design/cartPkg.sv
design/sccPkg.sv
design/megaromMapper.sv
design/sccSound.sv
design/readCombiner.sv
design/megaromCartridge.sv
test/megaromCartridgeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the MegaROM cartridge testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module megaromCartridgeTb \
    -Mdir obj_dir

# The simulation status is judged from the log, so a failing run must not stop here
./obj_dir/VmegaromCartridgeTb 2>&1 | tee "$LOG" || true

if grep -qx "TESTS PASSED" "$LOG"; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed, see $LOG"
    exit 1
fi

/* test/megaromCartridgeTb.sv */
// Testbench for the MegaROM cartridge with SCC sound
// Drives slot bus cycles, models the cartridge memory and lets concurrent
// assertions compare responses and memory strobes with a reference model
`timescale 1ns/100ps

module megaromCartridgeTb;

    localparam int unsigned RAM_BASE  = 32'h1000;
    localparam int unsigned BANK_BITS = 7;
    // About 240 reads at 4 cycles and 180 writes at 2 cycles, so 4000 leaves a wide margin
    localparam int WATCHDOG_CYCLES = 4000;

    logic              CLK;
    logic              RESET_n;
    cartPkg::cpuReq_t  cpu;
    cartPkg::ramReq_t  ram;
    logic [7:0]        ramData;
    cartPkg::cpuResp_t resp;
    logic [9:0]        soundOut;

    logic [7:0]  mem [0:2**21-1];
    logic [7:0]  refMem [int];
    logic [7:0]  refBank [4];
    logic [3:0]  refEnable;
    logic [3:0]  refWritable;
    logic        refPlus;
    logic [7:0]  refWave [128];
    logic [20:0] expAddr;
    logic [7:0]  expData;
    logic        expWrite;
    logic        rdStrobe;
    logic        wrStrobe;
    logic        rdPending;
    logic [20:0] rdAddr;
    integer      seed;

    megaromCartridge #(
        .RAM_BASE (RAM_BASE),
        .BANK_BITS(BANK_BITS)
    ) u_dut (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .cpu     (cpu),
        .ram     (ram),
        .ramData (ramData),
        .resp    (resp),
        .soundOut(soundOut)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    assign rdStrobe = cpu.sltsl && cpu.rd;
    assign wrStrobe = cpu.sltsl && cpu.wr;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [7:0] patternByte(input int addr);
        return 8'((addr * 7) + 3);
    endfunction

    // Page number counted from the start of the slot window
    function automatic logic [1:0] pageOf(input logic [15:0] addr);
        return 2'((addr - 16'h4000) >> 13);
    endfunction

    function automatic logic [20:0] mapAddress(input logic [15:0] addr);
        logic [7:0] bankVal;
        bankVal = refBank[pageOf(addr)] & 8'((1 << BANK_BITS) - 1);
        return 21'(RAM_BASE + bankVal * 32'h2000 + (addr & 16'h1FFF));
    endfunction

    // Bytes never written by a test still hold the fill pattern
    function automatic logic [7:0] memContent(input logic [20:0] addr);
        if (refMem.exists(int'(addr))) begin
            return refMem[int'(addr)];
        end
        return patternByte(int'(addr));
    endfunction

    function automatic logic sccHit(input logic [15:0] addr);
        if (refPlus) begin
            return refBank[3][7] && addr >= 16'hB800 && addr <= 16'hB8FF;
        end
        return refBank[2][5:0] == 6'h3F && addr >= 16'h9800 && addr <= 16'h98FF;
    endfunction

    function automatic logic isBankReg(input logic [15:0] addr);
        return (addr & 16'hF800) inside {16'h5000, 16'h7000, 16'h9000, 16'hB000};
    endfunction

    function automatic logic isModeReg(input logic [15:0] addr);
        return addr == 16'hBFFE || addr == 16'hBFFF;
    endfunction

    // Memory answers one cycle after ram.rd and holds the byte until the next read
    always @(posedge CLK) begin
        if (ram.wr) begin
            mem[ram.addr] = ram.data;
        end
        rdPending = ram.rd;
        rdAddr    = ram.addr;
        #1;
        if (rdPending) begin
            ramData = mem[rdAddr];
        end
    end

    task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
        logic [1:0] page;
        logic       hit;
        page = pageOf(addr);
        hit  = sccHit(addr);
        @(posedge CLK);
        #1;
        expAddr  = mapAddress(addr);
        expWrite = refWritable[page] && !isModeReg(addr);
        cpu      = '{addr: addr, data: data, rd: 1'b0, wr: 1'b1, sltsl: 1'b1};
        @(posedge CLK);
        #1;
        cpu.wr    = 1'b0;
        cpu.sltsl = 1'b0;
        // The reference moves on with the state seen before this write
        if (isModeReg(addr)) begin
            refPlus = data[5];
            if (data[4]) begin
                refEnable   = 4'h0;
                refWritable = 4'hF;
            end else begin
                refEnable   = {~data[2:0], 1'b1};
                refWritable = {data[2:0], 1'b0};
            end
        end else if (isBankReg(addr) && refEnable[page] && !refWritable[page]) begin
            refBank[page] = data;
        end
        if (expWrite) begin
            refMem[int'(expAddr)] = data;
        end
        if (hit && !addr[7]) begin
            refWave[addr[6:0]] = data;
        end
    endtask

    task automatic busRead(input logic [15:0] addr);
        int waited;
        @(posedge CLK);
        #1;
        expAddr  = mapAddress(addr);
        expData  = sccHit(addr) ? refWave[addr[6:0]] : memContent(mapAddress(addr));
        expWrite = 1'b0;
        cpu      = '{addr: addr, data: 8'h00, rd: 1'b1, wr: 1'b0, sltsl: 1'b1};
        @(posedge CLK);
        #1;
        cpu.rd    = 1'b0;
        cpu.sltsl = 1'b0;
        waited    = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (!resp.valid && waited < 6);
        if (!resp.valid) begin
            stopOnError("no read response arrived within 6 cycles");
        end
    endtask

    task automatic readPageRandom(input int page, input int count);
        logic [15:0] addr;
        repeat (count) begin
            addr = 16'h4000 + 16'(page) * 16'h2000 + (16'($random(seed)) & 16'h1FFF);
            busRead(addr);
        end
    endtask

    // Response arrives exactly three cycles after the strobe with the modelled byte
    respValid: assert property (@(posedge CLK) disable iff (!RESET_n)
        $past(rdStrobe, 3) |-> resp.valid)
        else stopOnError("FAIL resp.valid got 0 expected 1");

    respData: assert property (@(posedge CLK) disable iff (!RESET_n)
        $past(rdStrobe, 3) |-> resp.data == expData)
        else stopOnError($sformatf("FAIL resp.data got %02h expected %02h",
                                   $sampled(resp.data), $sampled(expData)));

    respNoStray: assert property (@(posedge CLK) disable iff (!RESET_n)
        resp.valid |-> $past(rdStrobe, 3))
        else stopOnError("resp.valid pulsed without a read three cycles earlier");

    ramReadAddr: assert property (@(posedge CLK) disable iff (!RESET_n)
        $past(rdStrobe) |-> ram.rd && ram.addr == expAddr)
        else stopOnError($sformatf("FAIL ram.rd/ram.addr got %h/%06h expected 1/%06h",
                                   $sampled(ram.rd), $sampled(ram.addr), $sampled(expAddr)));

    ramWriteDone: assert property (@(posedge CLK) disable iff (!RESET_n)
        $past(wrStrobe && expWrite) |-> ram.wr && ram.addr == expAddr &&
                                         ram.data == $past(cpu.data))
        else stopOnError($sformatf("FAIL ram.wr/addr/data got %h/%06h/%02h expected 1/%06h/%02h",
                                   $sampled(ram.wr), $sampled(ram.addr), $sampled(ram.data),
                                   $sampled(expAddr), $past(cpu.data)));

    ramNoWrite: assert property (@(posedge CLK) disable iff (!RESET_n)
        ram.wr |-> $past(wrStrobe && expWrite))
        else stopOnError("ram.wr raised for a write that must not reach memory");

    // Channels play but every volume keeps its reset value of 0, so the mixer stays silent
    soundQuiet: assert property (@(posedge CLK) disable iff (!RESET_n)
        soundOut == 10'h0)
        else stopOnError($sformatf("FAIL soundOut got %03h expected 000", $sampled(soundOut)));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        stopOnError("watchdog expired before the tests finished");
    end

    initial begin
        seed        = 32'h5417;
        cpu         = '0;
        ramData     = 8'h00;
        RESET_n     = 1'b0;
        expAddr     = '0;
        expData     = '0;
        expWrite    = 1'b0;
        refBank     = '{8'd0, 8'd1, 8'd2, 8'd3};
        refEnable   = 4'hF;
        refWritable = 4'h0;
        refPlus     = 1'b0;
        for (int a = 0; a < 2**21; a++) begin
            mem[a] = patternByte(a);
        end
        repeat (4) @(posedge CLK);
        #1;
        RESET_n = 1'b1;
        assert (!resp.valid && !ram.rd && !ram.wr && soundOut == 10'h0)
            else stopOnError("outputs not idle after reset");

        // Reset banks map page i onto block i
        for (int p = 0; p < 4; p++) begin
            readPageRandom(p, 4);
        end

        // Bank switching on every page where bit 7 of some values lies beyond BANK_BITS
        busWrite(16'h5000, 8'h15);
        busWrite(16'h7000, 8'h8A);
        busWrite(16'h9000, 8'h22);
        busWrite(16'hB000, 8'hF3);
        for (int p = 0; p < 4; p++) begin
            readPageRandom(p, 4);
        end

        // Plain SCC window at 9800h with bank 2 at 3Fh
        busWrite(16'h9000, 8'h3F);
        for (int i = 0; i < 128; i++) begin
            busWrite(16'h9800 + 16'(i), 8'($random(seed)));
        end
        // All five channels step through their waves at the shortest period
        busWrite(16'h988F, 8'h1F);
        for (int i = 0; i < 128; i++) begin
            busRead(16'h9800 + 16'(i));
        end
        busWrite(16'h9000, 8'h3E);
        for (int i = 0; i < 8; i++) begin
            busRead(16'h9800 + 16'(i * 16));
        end
        // Only the low six bits of bank 2 open the window
        busWrite(16'h9000, 8'hFF);
        for (int i = 0; i < 4; i++) begin
            busRead(16'h9800 + 16'(i * 3));
        end

        // Second mode moves the window to B800h behind bank 3 bit 7
        busWrite(16'hB000, 8'h80);
        busWrite(16'h9000, 8'h3F);
        busWrite(16'hBFFE, 8'h20);
        for (int i = 0; i < 8; i++) begin
            busRead(16'h9800 + 16'(i * 16));
        end
        for (int i = 0; i < 16; i++) begin
            busWrite(16'hB800 + 16'(i), 8'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            busRead(16'hB800 + 16'(i));
        end
        busWrite(16'hB000, 8'h05);
        for (int i = 0; i < 4; i++) begin
            busRead(16'hB800 + 16'(i));
        end
        busWrite(16'h9000, 8'h12);

        // Protected pages keep their contents
        busWrite(16'h4123, 8'hA1);
        busWrite(16'h6456, 8'hB2);
        busWrite(16'h8789, 8'hC3);
        busWrite(16'hA9AB, 8'hD4);
        busRead(16'h4123);
        busRead(16'h6456);
        busRead(16'h8789);
        busRead(16'hA9AB);

        // Bit 4 turns every page into RAM and locks the bank registers
        busWrite(16'hBFFE, 8'h10);
        busWrite(16'h4123, 8'h5E);
        busWrite(16'h6456, 8'h6F);
        busWrite(16'h8789, 8'h70);
        busWrite(16'hA9AB, 8'h81);
        busWrite(16'h5000, 8'h92);
        busWrite(16'hB000, 8'h03);
        busRead(16'h4123);
        busRead(16'h6456);
        busRead(16'h8789);
        busRead(16'hA9AB);
        busRead(16'h5000);
        busRead(16'hB000);
        readPageRandom(0, 2);

        // Bits 0 and 2 make pages 1 and 3 writable while pages 0 and 2 keep switching
        busWrite(16'hBFFF, 8'h05);
        busWrite(16'h7000, 8'h5A);
        busWrite(16'h9000, 8'h30);
        busWrite(16'h5000, 8'h0C);
        busWrite(16'hB000, 8'h77);
        busRead(16'h7000);
        busRead(16'hB000);
        for (int p = 0; p < 4; p++) begin
            readPageRandom(p, 2);
        end

        // Bit 1 alone swaps the roles of pages 1 to 3
        busWrite(16'hBFFE, 8'h02);
        busWrite(16'h7000, 8'h21);
        busWrite(16'h9000, 8'h99);
        busWrite(16'hB000, 8'h44);
        busRead(16'h9000);
        for (int p = 0; p < 4; p++) begin
            readPageRandom(p, 2);
        end
        busWrite(16'hBFFE, 8'h00);
        for (int p = 0; p < 4; p++) begin
            readPageRandom(p, 2);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* design/megaromCartridge.sv */
// MegaROM cartridge with SCC sound
// Top level joining the mapper, the SCC block and the read response path
`timescale 1ns/100ps

module megaromCartridge #(
    parameter int unsigned RAM_BASE  = 0,
    parameter int unsigned BANK_BITS = 8
) (
    input  logic              CLK,
    input  logic              RESET_n,
    input  cartPkg::cpuReq_t  cpu,
    output cartPkg::ramReq_t  ram,
    input  logic [7:0]        ramData,
    output cartPkg::cpuResp_t resp,
    output logic [9:0]        soundOut
);

    cartPkg::bankRegs_t banks;
    sccPkg::pageCtrl_t  pageCtrl;
    sccPkg::sccRead_t   sccRd;
    logic               memRead;

    // Mapper uses the SCC page flags and hands its bank values back
    megaromMapper #(
        .RAM_BASE (RAM_BASE),
        .BANK_BITS(BANK_BITS)
    ) u_mapper (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .cpu     (cpu),
        .pageCtrl(pageCtrl),
        .ram     (ram),
        .banks   (banks),
        .memRead (memRead)
    );

    sccSound u_scc (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .cpu     (cpu),
        .banks   (banks),
        .pageCtrl(pageCtrl),
        .sccRd   (sccRd),
        .soundOut(soundOut)
    );

    // Both read results arrive together and leave as one response
    readCombiner u_read (
        .CLK    (CLK),
        .RESET_n(RESET_n),
        .memRead(memRead),
        .ramData(ramData),
        .sccRd  (sccRd),
        .resp   (resp)
    );

endmodule

/* design/readCombiner.sv */
// CPU read response builder
// Picks the SCC byte or the cartridge memory byte and returns it as one
// registered response with a single cycle valid pulse
`timescale 1ns/100ps

module readCombiner (
    input  logic              CLK,
    input  logic              RESET_n,
    input  logic              memRead,
    input  logic [7:0]        ramData,
    input  sccPkg::sccRead_t  sccRd,
    output cartPkg::cpuResp_t resp
);

    logic [7:0] merged;
    logic       validQ;
    logic [7:0] dataQ;

    // The SCC hit and memRead line up in the same cycle
    // A hit overrides whatever the memory returned for that address
    assign merged = sccRd.hit ? sccRd.data : ramData;

    // Valid follows memRead by one cycle and lasts one cycle
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            validQ <= 1'b0;
        end else begin
            validQ <= memRead;
        end
    end

    // The byte is held between responses
    always_ff @(posedge CLK) begin
        if (memRead) begin
            dataQ <= merged;
        end
    end

    assign resp = '{valid: validQ, data: dataQ};

endmodule

/* design/sccSound.sv */
// SCC sound block of the MegaROM cartridge
// Holds the mode register with the page control flags, decodes the register
// window from the bank values, and runs five wave channels into a mixer
`timescale 1ns/100ps

module sccSound (
    input  logic               CLK,
    input  logic               RESET_n,
    input  cartPkg::cpuReq_t   cpu,
    input  cartPkg::bankRegs_t banks,
    output sccPkg::pageCtrl_t  pageCtrl,
    output sccPkg::sccRead_t   sccRd,
    output logic [9:0]         soundOut
);

    sccPkg::sccMode_e   mode;
    logic               modeWr;
    logic               winOpen;
    logic               csRd;
    logic               csWr;
    logic [7:0]         offQ;
    logic [7:0]         dinQ;
    logic [2:0]         volIdx;
    logic [7:0]         wave [128];
    logic [11:0]        freq [5];
    logic [3:0]         volume [5];
    logic [4:0]         chEnable;
    logic [11:0]        periodCnt [5];
    logic [4:0]         wavePtr [5];
    logic signed [7:0]  sample [5];
    logic signed [14:0] mixSum;
    logic               hitQ;
    logic [7:0]         rdDataQ;

    // Mode register answers at BFFEh and BFFFh
    assign modeWr = cpu.sltsl && cpu.wr && cpu.addr[15:1] == 15'h5FFF;

    // Bit 5 picks the mode
    // Bit 4 opens every page for writing, otherwise bits 0-2 do it for pages 1-3
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            mode     <= sccPkg::SCC_PLAIN;
            pageCtrl <= '{bankEnable: 4'hF, writable: 4'h0};
        end else if (modeWr) begin
            mode <= cpu.data[5] ? sccPkg::SCC_PLUS : sccPkg::SCC_PLAIN;
            if (cpu.data[4]) begin
                pageCtrl <= '{bankEnable: 4'h0, writable: 4'hF};
            end else begin
                pageCtrl <= '{bankEnable: {~cpu.data[2:0], 1'b1},
                              writable:   {cpu.data[2:0], 1'b0}};
            end
        end
    end

    // Plain mode needs bank 2 at 3Fh, the other mode needs bank 3 bit 7
    assign winOpen = (mode == sccPkg::SCC_PLAIN) ?
                     (banks[2][5:0] == 6'h3F && cpu.addr[15:8] == 8'h98) :
                     (banks[3][7] && cpu.addr[15:8] == 8'hB8);

    // First stage registers the chip select with the offset and write data
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            csRd <= 1'b0;
            csWr <= 1'b0;
        end else begin
            csRd <= cpu.sltsl && cpu.rd && winOpen;
            csWr <= cpu.sltsl && cpu.wr && winOpen;
        end
    end

    always_ff @(posedge CLK) begin
        if (cpu.sltsl && winOpen) begin
            offQ <= cpu.addr[7:0];
            dinQ <= cpu.data;
        end
    end

    // Volume registers start at 8Ah
    assign volIdx = 3'(offQ[3:0] - 4'hA);

    // Wave memory takes offsets 00h-7Fh, 32 bytes per channel
    always_ff @(posedge CLK) begin
        if (csWr && !offQ[7]) begin
            wave[offQ[6:0]] <= dinQ;
        end
    end

    // Even offsets hold the low frequency byte, odd ones the top nibble
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int ch = 0; ch < 5; ch++) begin
                freq[ch]   <= '0;
                volume[ch] <= '0;
            end
            chEnable <= '0;
        end else if (csWr && offQ[7:4] == 4'h8) begin
            case (offQ[3:0])
                4'h0, 4'h2, 4'h4, 4'h6, 4'h8: freq[offQ[3:1]][7:0] <= dinQ;
                4'h1, 4'h3, 4'h5, 4'h7, 4'h9: freq[offQ[3:1]][11:8] <= dinQ[3:0];
                4'hA, 4'hB, 4'hC, 4'hD, 4'hE: volume[volIdx] <= dinQ[3:0];
                default: chEnable <= dinQ[4:0];
            endcase
        end
    end

    // Second stage returns wave bytes and reads FFh for the control registers
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            hitQ <= 1'b0;
        end else begin
            hitQ <= csRd;
        end
    end

    always_ff @(posedge CLK) begin
        if (csRd) begin
            rdDataQ <= offQ[7] ? 8'hFF : wave[offQ[6:0]];
        end
    end

    assign sccRd = '{hit: hitQ, data: rdDataQ};

    // Each period counter reloads from its frequency register when it runs out
    // An enabled channel then moves on to the next wave sample
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int ch = 0; ch < 5; ch++) begin
                periodCnt[ch] <= '0;
                wavePtr[ch]   <= '0;
            end
        end else begin
            for (int ch = 0; ch < 5; ch++) begin
                if (periodCnt[ch] == 12'd0) begin
                    periodCnt[ch] <= freq[ch];
                    if (chEnable[ch]) begin
                        wavePtr[ch] <= wavePtr[ch] + 5'd1;
                    end
                end else begin
                    periodCnt[ch] <= periodCnt[ch] - 12'd1;
                end
            end
        end
    end

    // Channel 5 plays from the wave table of channel 4
    always_comb begin
        for (int ch = 0; ch < 5; ch++) begin
            sample[ch] = wave[{((ch == 4) ? 2'd3 : 2'(ch)), wavePtr[ch]}];
        end
    end

    // Signed sample times unsigned volume, summed over the enabled channels
    always_comb begin
        logic signed [12:0] prod;
        mixSum = '0;
        for (int ch = 0; ch < 5; ch++) begin
            prod = sample[ch] * $signed({1'b0, volume[ch]});
            if (chEnable[ch]) begin
                mixSum = mixSum + {{2{prod[12]}}, prod};
            end
        end
    end

    assign soundOut = mixSum[14:5];

    // Read data only comes back for a CPU read two cycles earlier
    hitNeedsRead: assert property (@(posedge CLK) disable iff (!RESET_n)
        hitQ |-> $past(cpu.sltsl && cpu.rd, 2))
        else $error("sccRd.hit without a read strobe");

endmodule

/* design/megaromMapper.sv */
// Konami SCC style MegaROM mapper
// Splits 4000h-BFFFh into four 8 KB pages, each with its own bank register,
// and turns CPU cycles into registered strobes on the cartridge memory
`timescale 1ns/100ps

module megaromMapper #(
    parameter int unsigned RAM_BASE  = 0,
    parameter int unsigned BANK_BITS = 8
) (
    input  logic               CLK,
    input  logic               RESET_n,
    input  cartPkg::cpuReq_t   cpu,
    input  sccPkg::pageCtrl_t  pageCtrl,
    output cartPkg::ramReq_t   ram,
    output cartPkg::bankRegs_t banks,
    output logic               memRead
);

    localparam int AW = cartPkg::RAM_ADDR_W;

    logic                 inWindow;
    logic [1:0]           pageIdx;
    logic                 bankAddr;
    logic                 modeAddr;
    logic [BANK_BITS-1:0] bankSel;
    logic [AW-1:0]        mapAddr;
    logic                 bankWr;
    logic                 memWr;
    logic                 memRd;
    cartPkg::bankRegs_t   bankQ;
    logic                 ramRdQ;
    logic                 ramWrQ;
    logic [AW-1:0]        ramAddrQ;
    logic [7:0]           ramDataQ;
    logic                 memReadQ;

    // The slot window is 4000h-BFFFh and the page is picked by A15 and A13
    assign inWindow = cpu.sltsl && (cpu.addr[15:14] == 2'b01 || cpu.addr[15:14] == 2'b10);
    assign pageIdx  = {cpu.addr[15], cpu.addr[13]};

    // Bank registers sit in the lower 2 KB of the upper half of each page
    // So 5000h, 7000h, 9000h and B000h each cover 800h bytes
    assign bankAddr = cpu.addr[12:11] == 2'b10;

    // BFFEh and BFFFh belong to the SCC mode register and never reach memory
    assign modeAddr = cpu.addr[15:1] == 15'h5FFF;

    // Only the low BANK_BITS of the bank value select the 8 KB block
    assign bankSel = bankQ[pageIdx][BANK_BITS-1:0];
    assign mapAddr = AW'(RAM_BASE) + (AW'(bankSel) << 13) + AW'(cpu.addr[12:0]);

    // A writable page takes the data into memory instead of its bank register
    assign bankWr = inWindow && cpu.wr && bankAddr &&
                    pageCtrl.bankEnable[pageIdx] && !pageCtrl.writable[pageIdx];
    assign memWr  = inWindow && cpu.wr && pageCtrl.writable[pageIdx] && !modeAddr;
    assign memRd  = inWindow && cpu.rd;

    // Bank registers come out of reset mapping page i onto block i
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            bankQ <= {8'd3, 8'd2, 8'd1, 8'd0};
        end else if (bankWr) begin
            bankQ[pageIdx] <= cpu.data;
        end
    end

    // Memory strobes follow the CPU strobe by one cycle
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ramRdQ   <= 1'b0;
            ramWrQ   <= 1'b0;
            memReadQ <= 1'b0;
        end else begin
            ramRdQ   <= memRd;
            ramWrQ   <= memWr;
            // Memory data is valid in the cycle after ram.rd
            memReadQ <= ramRdQ;
        end
    end

    // Address and write data are captured on every cycle with a strobe
    always_ff @(posedge CLK) begin
        if (memRd || memWr) begin
            ramAddrQ <= mapAddr;
            ramDataQ <= cpu.data;
        end
    end

    assign ram     = '{addr: ramAddrQ, data: ramDataQ, rd: ramRdQ, wr: ramWrQ};
    assign banks   = bankQ;
    assign memRead = memReadQ;

    // The memory can only see one kind of strobe in a cycle
    rdWrExclusive: assert property (@(posedge CLK) disable iff (!RESET_n)
        !(ramRdQ && ramWrQ))
        else $error("ram.rd and ram.wr high together");

    // A memory write needs the page to have been writable when the CPU wrote
    wrNeedsWritable: assert property (@(posedge CLK) disable iff (!RESET_n)
        ramWrQ |-> $past(pageCtrl.writable[pageIdx]))
        else $error("ram.wr on a write protected page");

endmodule

/* design/sccPkg.sv */
// SCC sound chip definitions
// Mode encoding, page control flags and the register read result
package sccPkg;

    // Plain SCC places its window at 9800h and SCC-I style mode at B800h
    typedef enum logic {
        SCC_PLAIN = 1'b0,
        SCC_PLUS  = 1'b1
    } sccMode_e;

    // Per page flags driven from the mode register into the mapper
    // Bit i belongs to page i in both fields
    typedef struct packed {
        logic [3:0] bankEnable;
        logic [3:0] writable;
    } pageCtrl_t;

    // Result of a CPU read inside the SCC register window
    // A set hit means data replaces the memory byte
    typedef struct packed {
        logic       hit;
        logic [7:0] data;
    } sccRead_t;

endpackage

/* design/cartPkg.sv */
// Slot bus and cartridge memory definitions
// Shared by the mapper, the SCC block, the read path and the top level
package cartPkg;

    // Cartridge memory address width covers 2 MB of ROM or RAM
    localparam int RAM_ADDR_W = 21;

    // One CPU bus cycle as seen on the cartridge slot
    // Each strobe is active high and only counts together with sltsl
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
        logic        sltsl;
    } cpuReq_t;

    // Request towards the external cartridge memory
    // Read data comes back one cycle after rd and is held until the next read
    typedef struct packed {
        logic [RAM_ADDR_W-1:0] addr;
        logic [7:0]            data;
        logic                  rd;
        logic                  wr;
    } ramReq_t;

    // Read response back to the CPU with a single cycle valid pulse
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } cpuResp_t;

    // Bank values of the four 8 KB pages at 4000h, 6000h, 8000h and A000h
    typedef logic [3:0][7:0] bankRegs_t;

endpackage
